// File: debugLinkPkg.sv
package debugLinkPkg;

    // ========================================
    // Message format
    // ========================================

    // Payload capacity of a message in bytes
    localparam int MsgMaxPayloadLen = 5;

    // Message types
    localparam logic [7:0] MsgTypeNop = 8'h00;
    localparam logic [7:0] MsgTypeSetLed = 8'h01;

    // Number of led outputs driven by SetLed
    localparam int LedWidth = 4;

    // ========================================
    // Payload views
    // ========================================

    // SetLed command: value in byte 0, rest of the payload ignored
    typedef struct packed {
        logic [MsgMaxPayloadLen-2:0][7:0] unused;
        logic [7:0]                       ledValue;
    } setLedCmd_t;

    // Payload word, written by byte index and decoded per command
    typedef union packed {
        logic [MsgMaxPayloadLen-1:0][7:0] bytes;
        setLedCmd_t                       setLed;
    } msgPayload_t;

endpackage

// File: serialDeframer.sv
`timescale 1ns/1ps

module serialDeframer
    import debugLinkPkg::*;
#(
    parameter int MaxPayloadLen = MsgMaxPayloadLen
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        serialCs,
    input  logic        serialDi,
    output logic        inValid,
    input  logic        inReady,
    output logic [7:0]  inType,
    output logic [7:0]  inLen,
    output msgPayload_t inPayload
);

    localparam logic [1:0] StateType = 2'd0;
    localparam logic [1:0] StateLen = 2'd1;
    localparam logic [1:0] StatePayload = 2'd2;

    logic [7:0] shiftReg;
    logic       byteDone;
    logic [7:0] rxByte;
    logic [1:0] state;
    logic [7:0] payloadCount;
    logic       payloadWr;

    // Sentinel reaches bit 7 after seven bits and the eighth arrives on serialDi
    assign byteDone = serialCs && shiftReg[7];
    assign rxByte = {shiftReg[6:0], serialDi};
    assign payloadWr = byteDone && (state == StatePayload) &&
                       (payloadCount < MaxPayloadLen);

    // ========================================
    // Bit shifter
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || !serialCs || byteDone) begin
            shiftReg <= 8'h01;
        end else begin
            shiftReg <= {shiftReg[6:0], serialDi};
        end
    end

    // ========================================
    // Message FSM
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || !serialCs) begin
            state <= StateType;
            payloadCount <= 8'd0;
            inValid <= 1'b0;
        end else begin
            inValid <= 1'b0;
            if (byteDone) begin
                case (state)
                    StateType: begin
                        // Nop bytes keep us on the byte boundary
                        if (rxByte != MsgTypeNop) begin
                            state <= StateLen;
                        end
                    end
                    StateLen: begin
                        payloadCount <= 8'd0;
                        if (rxByte == 8'd0) begin
                            inValid <= 1'b1;
                            state <= StateType;
                        end else begin
                            state <= StatePayload;
                        end
                    end
                    default: begin
                        payloadCount <= payloadCount + 8'd1;
                        if (payloadCount + 8'd1 == inLen) begin
                            inValid <= 1'b1;
                            state <= StateType;
                        end
                    end
                endcase
            end
        end
    end

    // Message registers hold until the next message starts
    always_ff @(posedge clk) begin
        if (byteDone && state == StateType && rxByte != MsgTypeNop) begin
            inType <= rxByte;
            inPayload <= '0;
        end
        if (byteDone && state == StateLen) begin
            inLen <= rxByte;
        end
        if (payloadWr) begin
            inPayload.bytes[payloadCount] <= rxByte;
        end
    end

    payloadInRange: assert property (@(posedge clk) disable iff (rst)
        payloadWr |-> payloadCount < MsgMaxPayloadLen);

endmodule

// File: msgQueue.sv
`timescale 1ns/1ps

module msgQueue
    import debugLinkPkg::*;
#(
    parameter int Depth = 4,
    parameter int MaxPayloadLen = MsgMaxPayloadLen
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        inValid,
    output logic        inReady,
    input  logic [7:0]  inType,
    input  logic [7:0]  inLen,
    input  msgPayload_t inPayload,
    output logic        outValid,
    input  logic        outReady,
    output logic [7:0]  outType,
    output logic [7:0]  outLen,
    output msgPayload_t outPayload
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountW = $clog2(Depth + 1);

    // Only the bytes the deframer can fill are stored
    logic [7:0]                    typeMem [Depth];
    logic [7:0]                    lenMem [Depth];
    logic [MaxPayloadLen-1:0][7:0] payloadMem [Depth];

    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [CountW-1:0] count;
    logic              wrEn;
    logic              rdEn;

    assign inReady = (count != CountW'(Depth));
    assign outValid = (count != '0);
    assign wrEn = inValid && inReady;
    assign rdEn = outValid && outReady;

    // Head entry drives the outputs directly
    assign outType = typeMem[rdPtr];
    assign outLen = lenMem[rdPtr];
    always_comb begin
        outPayload = '0;
        outPayload.bytes[MaxPayloadLen-1:0] = payloadMem[rdPtr];
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            typeMem[wrPtr] <= inType;
            lenMem[wrPtr] <= inLen;
            payloadMem[wrPtr] <= inPayload.bytes[MaxPayloadLen-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            count <= count + CountW'(wrEn) - CountW'(rdEn);
        end
    end

    // A write while full or a read while empty pulls the pointers away from the count
    noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
        count == CountW'(Depth) |-> wrPtr == rdPtr);

    noReadWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        count == '0 |-> wrPtr == rdPtr);

endmodule

// File: cmdHandler.sv
`timescale 1ns/1ps

module cmdHandler
    import debugLinkPkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                outValid,
    output logic                outReady,
    input  logic [7:0]          outType,
    input  logic [7:0]          outLen,
    input  msgPayload_t         outPayload,
    output logic                txValid,
    input  logic                txReady,
    output logic [7:0]          txByte,
    output logic [LedWidth-1:0] led
);

    localparam logic [1:0] StateIdle = 2'd0;
    localparam logic [1:0] StateType = 2'd1;
    localparam logic [1:0] StateLen = 2'd2;
    localparam logic [1:0] StateData = 2'd3;

    logic [1:0]          state;
    logic [7:0]          replyType;
    logic [7:0]          replyLen;
    logic [7:0]          replyData;
    logic [LedWidth-1:0] ledNext;
    logic                accept;
    logic                isSetLed;

    assign outReady = (state == StateIdle);
    assign accept = outValid && outReady;
    assign isSetLed = (outType == MsgTypeSetLed);

    // Decode through the command view; an empty SetLed leaves led as is
    assign ledNext = (outLen != 8'd0) ? outPayload.setLed.ledValue[LedWidth-1:0] : led;

    // ========================================
    // Reply byte mux
    // ========================================
    assign txValid = (state != StateIdle);
    always_comb begin
        case (state)
            StateType: txByte = replyType;
            StateLen:  txByte = replyLen;
            default:   txByte = replyData;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
            led <= '0;
        end else begin
            case (state)
                StateIdle: begin
                    if (accept) begin
                        state <= StateType;
                        if (isSetLed) begin
                            led <= ledNext;
                        end
                    end
                end
                StateType: begin
                    if (txReady) state <= StateLen;
                end
                StateLen: begin
                    if (txReady) begin
                        state <= (replyLen != 8'd0) ? StateData : StateIdle;
                    end
                end
                default: begin
                    if (txReady) state <= StateIdle;
                end
            endcase
        end
    end

    // Reply contents, captured with the message
    always_ff @(posedge clk) begin
        if (accept) begin
            replyType <= outType;
            replyLen <= isSetLed ? 8'd1 : 8'd0;
            replyData <= {{(8 - LedWidth){1'b0}}, ledNext};
        end
    end

    txHoldsWhileStalled: assert property (@(posedge clk) disable iff (rst)
        txValid && !txReady |=> txValid && $stable(txByte));

endmodule

// File: serialFramer.sv
`timescale 1ns/1ps

module serialFramer (
    input  logic       clk,
    input  logic       rst,
    input  logic       serialCs,
    input  logic       txValid,
    output logic       txReady,
    input  logic [7:0] txByte,
    output logic       serialDo
);

    // Data in the top eight bits, sentinel trailing behind it
    logic [8:0] shiftReg;
    logic       boundary;
    logic [7:0] nextByte;

    assign serialDo = shiftReg[8];

    // Sentinel at bit 7 means the last bit of the byte is on the line
    assign boundary = serialCs && (shiftReg[7:0] == 8'h80);
    assign txReady = boundary;

    // Zero idle byte when the handler has nothing to send
    assign nextByte = txValid ? txByte : 8'h00;

    // ========================================
    // Output shifter
    // ========================================
    always_ff @(posedge clk) begin
        if (rst || !serialCs) begin
            // Parked on a boundary so the first byte loads right away
            shiftReg <= 9'h080;
        end else if (boundary) begin
            shiftReg <= {nextByte, 1'b1};
        end else begin
            shiftReg <= {shiftReg[7:0], 1'b0};
        end
    end

endmodule

// File: debugLink.sv
`timescale 1ns/1ps

module debugLink
    import debugLinkPkg::*;
#(
    parameter int MaxPayloadLen = MsgMaxPayloadLen,
    parameter int FifoDepth = 4
)(
    input  logic                clk,
    input  logic                rst,
    input  logic                serialCs,
    input  logic                serialDi,
    output logic                serialDo,
    output logic [LedWidth-1:0] led
);

    // Deframer to queue
    logic        inValid;
    logic        inReady;
    logic [7:0]  inType;
    logic [7:0]  inLen;
    msgPayload_t inPayload;

    // Queue to handler
    logic        outValid;
    logic        outReady;
    logic [7:0]  outType;
    logic [7:0]  outLen;
    msgPayload_t outPayload;

    // Handler to framer
    logic       txValid;
    logic       txReady;
    logic [7:0] txByte;

    // ========================================
    // Receive path
    // ========================================
    serialDeframer #(
        .MaxPayloadLen(MaxPayloadLen)
    ) serialDeframer_inst (
        .clk(clk),
        .rst(rst),
        .serialCs(serialCs),
        .serialDi(serialDi),
        .inValid(inValid),
        .inReady(inReady),
        .inType(inType),
        .inLen(inLen),
        .inPayload(inPayload)
    );

    msgQueue #(
        .Depth(FifoDepth),
        .MaxPayloadLen(MaxPayloadLen)
    ) msgQueue_inst (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inType(inType),
        .inLen(inLen),
        .inPayload(inPayload),
        .outValid(outValid),
        .outReady(outReady),
        .outType(outType),
        .outLen(outLen),
        .outPayload(outPayload)
    );

    // ========================================
    // Command and reply path
    // ========================================
    cmdHandler cmdHandler_inst (
        .clk(clk),
        .rst(rst),
        .outValid(outValid),
        .outReady(outReady),
        .outType(outType),
        .outLen(outLen),
        .outPayload(outPayload),
        .txValid(txValid),
        .txReady(txReady),
        .txByte(txByte),
        .led(led)
    );

    serialFramer serialFramer_inst (
        .clk(clk),
        .rst(rst),
        .serialCs(serialCs),
        .txValid(txValid),
        .txReady(txReady),
        .txByte(txByte),
        .serialDo(serialDo)
    );

endmodule

// File: debugLinkTb.sv
`timescale 1ns/1ps

module debugLinkTb import debugLinkPkg::*; ();

    localparam int          ReplyTimeoutBytes = 64;
    localparam int          IdleTimeoutBytes = 16;
    localparam int          OtherMsgCount = 6;
    localparam int          RandomMsgCount = 20;
    localparam logic [31:0] Seed = 32'hb8c92786;

    logic                clk;
    logic                rst;
    logic                serialCs;
    logic                serialDi;
    logic                serialDo;
    logic [LedWidth-1:0] led;

    // Expected replies in arrival order
    logic [7:0]          expType [$];
    logic [7:0]          expLen [$];
    logic [7:0]          expData [$];
    logic [LedWidth-1:0] modelLed;

    int errorCount = 0;
    int replyCount = 0;
    int idleBytes = 0;

    // Serial output monitor state
    logic       outStarted;
    int         bitCount;
    logic [7:0] rxShift;
    logic [1:0] parseState;
    logic [7:0] gotType;
    logic [7:0] gotLen;
    logic [7:0] gotData;
    int         dataLeft;

    debugLink #(
        .MaxPayloadLen(MsgMaxPayloadLen),
        .FifoDepth(4)
    ) debugLink_inst (
        .clk(clk),
        .rst(rst),
        .serialCs(serialCs),
        .serialDi(serialDi),
        .serialDo(serialDo),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================
    // Reference model
    // ========================================
    function automatic void expectedReply(
        input  logic [7:0]          msgType,
        input  logic [7:0]          msgLen,
        input  logic [7:0]          firstByte,
        input  logic [LedWidth-1:0] ledIn,
        output logic [7:0]          repType,
        output logic [7:0]          repLen,
        output logic [7:0]          repData,
        output logic [LedWidth-1:0] ledOut
    );
        repType = msgType;
        ledOut = ledIn;
        if (msgType == MsgTypeSetLed) begin
            // Without a payload byte there is no new value
            if (msgLen != 8'd0) begin
                ledOut = firstByte[LedWidth-1:0];
            end
            repLen = 8'd1;
            repData = {{(8 - LedWidth){1'b0}}, ledOut};
        end else begin
            repLen = 8'd0;
            repData = 8'd0;
        end
    endfunction

    function automatic logic [7:0] randomOtherType();
        logic [31:0] rnd;
        rnd = ($urandom % 254) + 2;
        return rnd[7:0];
    endfunction

    // ========================================
    // Stimulus
    // ========================================
    task automatic sendByte(input logic [7:0] value);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            serialCs <= 1'b1;
            serialDi <= value[i];
        end
    endtask

    task automatic sendMessage(input logic [7:0] msgType, input logic [7:0] msgLen,
                               input logic [7:0] firstByte);
        logic [7:0]          repType;
        logic [7:0]          repLen;
        logic [7:0]          repData;
        logic [LedWidth-1:0] ledNext;
        logic [31:0]         rnd;
        expectedReply(msgType, msgLen, firstByte, modelLed, repType, repLen, repData, ledNext);
        modelLed = ledNext;
        expType.push_back(repType);
        expLen.push_back(repLen);
        expData.push_back(repData);
        sendByte(msgType);
        sendByte(msgLen);
        for (int i = 0; i < msgLen; i++) begin
            rnd = $urandom;
            sendByte((i == 0) ? firstByte : rnd[7:0]);
        end
        // Gap of nop bytes keeps the queue from filling
        sendByte(MsgTypeNop);
        sendByte(MsgTypeNop);
    endtask

    // Waits send nop bytes so the input stays on byte boundaries
    task automatic waitForReplies(input string what);
        int sent;
        sent = 0;
        @(negedge clk);
        while (expType.size() != 0 && sent < ReplyTimeoutBytes) begin
            sendByte(MsgTypeNop);
            @(negedge clk);
            sent++;
        end
        if (expType.size() != 0) begin
            errorCount++;
            $display("Timed out waiting for replies to %s, %0d still missing",
                     what, expType.size());
        end
    endtask

    task automatic waitForIdleBytes(input int count);
        int sent;
        sent = 0;
        @(negedge clk);
        while (idleBytes < count && sent < IdleTimeoutBytes) begin
            sendByte(MsgTypeNop);
            @(negedge clk);
            sent++;
        end
        if (idleBytes < count) begin
            errorCount++;
            $display("Timed out waiting for idle output bytes, saw %0d of %0d",
                     idleBytes, count);
        end
    endtask

    task automatic checkLed(input string what);
        assert (led == modelLed) else begin
            errorCount++;
            $display("[ERROR] %0t: led after %s is %h, expected %h", $time, what, led, modelLed);
        end
    endtask

    // ========================================
    // Serial output monitor
    // ========================================
    task automatic checkReply();
        logic [7:0] eType;
        logic [7:0] eLen;
        logic [7:0] eData;
        assert (expType.size() != 0) else begin
            errorCount++;
            $display("[ERROR] %0t: reply type %h arrived with none expected", $time, gotType);
        end
        if (expType.size() != 0) begin
            eType = expType.pop_front();
            eLen = expLen.pop_front();
            eData = expData.pop_front();
            assert (gotType == eType) else begin
                errorCount++;
                $display("[ERROR] %0t: reply type %h, expected %h", $time, gotType, eType);
            end
            assert (gotLen == eLen) else begin
                errorCount++;
                $display("[ERROR] %0t: reply length %0d, expected %0d", $time, gotLen, eLen);
            end
            if (eLen != 8'd0) begin
                assert (gotData == eData) else begin
                    errorCount++;
                    $display("[ERROR] %0t: reply data %h, expected %h", $time, gotData, eData);
                end
            end
            replyCount++;
        end
    endtask

    task automatic takeByte(input logic [7:0] value);
        case (parseState)
            2'd0: begin
                // Zero bytes between replies are idle fill
                if (value == 8'd0) begin
                    idleBytes++;
                end else begin
                    gotType = value;
                    parseState = 2'd1;
                end
            end
            2'd1: begin
                gotLen = value;
                gotData = 8'd0;
                dataLeft = value;
                if (value == 8'd0) begin
                    checkReply();
                    parseState = 2'd0;
                end else begin
                    parseState = 2'd2;
                end
            end
            default: begin
                if (dataLeft == gotLen) begin
                    gotData = value;
                end
                dataLeft--;
                if (dataLeft == 0) begin
                    checkReply();
                    parseState = 2'd0;
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        if (rst || !serialCs) begin
            outStarted = 1'b0;
            bitCount = 0;
            parseState = 2'd0;
        end else if (!outStarted) begin
            // First output byte loads on this edge
            outStarted = 1'b1;
        end else begin
            rxShift = {rxShift[6:0], serialDo};
            bitCount++;
            if (bitCount == 8) begin
                bitCount = 0;
                takeByte(rxShift);
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int unsigned seedVal;
        logic [31:0] rnd;
        logic [7:0]  msgType;
        logic [7:0]  msgLen;
        seedVal = Seed;
        void'($urandom(seedVal));
        rst = 1'b1;
        serialCs = 1'b0;
        serialDi = 1'b0;
        modelLed = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        // State right after reset
        checkLed("reset");
        assert (serialDo == 1'b0) else begin
            errorCount++;
            $display("[ERROR] %0t: serialDo is %b after reset, expected 0", $time, serialDo);
        end

        // Idle output is zero bytes only
        waitForIdleBytes(4);
        assert (parseState == 2'd0) else begin
            errorCount++;
            $display("[ERROR] %0t: reply bytes seen on the idle output", $time);
        end

        // SetLed with a random value
        rnd = $urandom;
        sendMessage(MsgTypeSetLed, 8'd1, rnd[7:0]);
        waitForReplies("SetLed");
        checkLed("SetLed");

        // Unknown types are echoed with length 0
        for (int i = 0; i < OtherMsgCount; i++) begin
            rnd = $urandom % (MsgMaxPayloadLen + 1);
            msgLen = rnd[7:0];
            rnd = $urandom;
            sendMessage(randomOtherType(), msgLen, rnd[7:0]);
        end
        waitForReplies("unknown types");

        // Nop bytes ahead of a message
        repeat (5) sendByte(MsgTypeNop);
        rnd = $urandom;
        sendMessage(MsgTypeSetLed, 8'd2, rnd[7:0]);
        waitForReplies("SetLed after nops");
        checkLed("SetLed after nops");

        // Oversized payload followed by a normal message
        rnd = $urandom;
        sendMessage(MsgTypeSetLed, 8'(MsgMaxPayloadLen + 3), rnd[7:0]);
        rnd = $urandom;
        sendMessage(randomOtherType(), 8'd2, rnd[7:0]);
        waitForReplies("oversized SetLed");
        checkLed("oversized SetLed");

        // Random message sequence
        for (int i = 0; i < RandomMsgCount; i++) begin
            rnd = $urandom;
            if (rnd[0]) begin
                msgType = MsgTypeSetLed;
                rnd = $urandom % (MsgMaxPayloadLen + 2);
                msgLen = rnd[7:0] + 8'd1;
            end else begin
                msgType = randomOtherType();
                rnd = $urandom % (MsgMaxPayloadLen + 3);
                msgLen = rnd[7:0];
            end
            rnd = $urandom;
            sendMessage(msgType, msgLen, rnd[7:0]);
        end
        waitForReplies("random sequence");
        checkLed("random sequence");

        $display("Summary: %0d errors, %0d replies checked", errorCount, replyCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: debugLink.f
debugLinkPkg.sv
serialDeframer.sv
msgQueue.sv
cmdHandler.sv
serialFramer.sv
debugLink.sv
debugLinkTb.sv
